/* src.f */
hdl/lsq_cfg_pkg.sv
hdl/lsq_types_pkg.sv
hdl/mem_req_if.sv
hdl/op_dispatch.sv
hdl/addr_comparator.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/mem_port_arbiter.sv
hdl/data_sram.sv
hdl/lsq_top.sv
dv/tb_lsq_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_lsq_top -o sim_lsq; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_lsq)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

/* dv/tb_lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsq_top;
	import lsq_cfg_pkg::*;

	localparam int N_INIT      = 8;
	localparam int N_BURST     = 6;
	localparam int N_PAIRS     = 8;
	localparam int N_RAND      = 400;
	localparam int N_OPS       = N_INIT + 2 * N_BURST + 2 * N_PAIRS + N_RAND;
	localparam int CYCLE_LIMIT = 20 * N_OPS + 200;
	localparam int DRAIN_LIMIT = 50;  // Cycles allowed for the last loads to return

	logic              i_clk = 1'b0;
	logic              i_reset;
	logic              i_op_valid;
	logic              o_op_ready;
	logic              i_op_is_store;
	logic [ADDR_W-1:0] i_op_addr;
	logic [DATA_W-1:0] i_op_wdata;
	logic [RD_W-1:0]   i_op_rd;
	logic              o_ld_valid;
	logic [RD_W-1:0]   o_ld_rd;
	logic [DATA_W-1:0] o_ld_data;

	// Reference model of 8 live words and expected {rd, data} in load order
	logic [DATA_W-1:0]      ref_mem [8];
	logic [RD_W+DATA_W-1:0] exp_q [$];

	// Mid-cycle snapshots that the assertions look at
	logic              s_ld_valid = 1'b0;
	logic [RD_W-1:0]   s_ld_rd = '0;
	logic [DATA_W-1:0] s_ld_data = '0;
	logic              s_exp_any = 1'b0;
	logic [RD_W-1:0]   s_exp_rd = '0;
	logic [DATA_W-1:0] s_exp_data = '0;
	logic              s_after_reset = 1'b0;
	logic              s_ready = 1'b0;
	logic              s_done = 1'b0;
	logic              s_exp_empty = 1'b1;

	logic              reset_prev = 1'b0;
	logic              p_stalled = 1'b0;  // Op offered and refused at the coming edge
	logic              stim_done = 1'b0;

	int data_errs = 0;
	int order_errs = 0;
	int other_errs = 0;
	int st_stalls = 0;
	int ld_stalls = 0;
	int cycles = 0;

	lsq_top i_dut (.*);

	always #2 i_clk = ~i_clk;

	// Reference model --------------------
	always @(negedge i_clk) begin
		s_ld_valid    = o_ld_valid;
		s_ld_rd       = o_ld_rd;
		s_ld_data     = o_ld_data;
		s_ready       = o_op_ready;
		s_after_reset = reset_prev && !i_reset;
		reset_prev    = i_reset;
		s_done        = stim_done;

		s_exp_any = (exp_q.size() != 0);
		{s_exp_rd, s_exp_data} = s_exp_any ? exp_q[0] : '0;
		if (!i_reset && o_ld_valid && s_exp_any)
			void'(exp_q.pop_front());

		p_stalled = !i_reset && i_op_valid && !o_op_ready;
		if (p_stalled) begin
			if (i_op_is_store)
				st_stalls++;
			else
				ld_stalls++;
		end

		// Transfer happens at the coming rising edge
		if (!i_reset && i_op_valid && o_op_ready) begin
			if (i_op_is_store)
				ref_mem[i_op_addr[2:0]] = i_op_wdata;
			else
				exp_q.push_back({i_op_rd, ref_mem[i_op_addr[2:0]]});
		end
		s_exp_empty = (exp_q.size() == 0);
	end

	// Checks --------------------
	a_reset_state: assert property (@(posedge i_clk) disable iff (i_reset)
		s_after_reset |-> (s_ready && !s_ld_valid))
		else begin
			other_errs++;
			$display("ERR after reset o_op_ready %h o_ld_valid %h", s_ready, s_ld_valid);
		end

	a_ld_data: assert property (@(posedge i_clk) disable iff (i_reset)
		(s_ld_valid && s_exp_any) |-> (s_ld_data == s_exp_data))
		else begin
			data_errs++;
			$display("ERR o_ld_data got %h expected %h", s_ld_data, s_exp_data);
		end

	a_ld_rd: assert property (@(posedge i_clk) disable iff (i_reset)
		(s_ld_valid && s_exp_any) |-> (s_ld_rd == s_exp_rd))
		else begin
			order_errs++;
			$display("ERR o_ld_rd got %h expected %h", s_ld_rd, s_exp_rd);
		end

	a_no_stray: assert property (@(posedge i_clk) disable iff (i_reset)
		s_ld_valid |-> s_exp_any)
		else begin
			order_errs++;
			$display("Load response arrived with no load outstanding");
		end

	a_drained: assert property (@(posedge i_clk) s_done |-> s_exp_empty)
		else begin
			order_errs++;
			$display("Accepted loads still without a response at the end");
		end

	// Stimulus --------------------
	task automatic send_op(input logic is_store, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [RD_W-1:0] rd);
		logic taken;
		i_op_valid    = 1'b1;
		i_op_is_store = is_store;
		i_op_addr     = addr;
		i_op_wdata    = data;
		i_op_rd       = rd;
		taken         = 1'b0;
		while (!taken) begin
			@(negedge i_clk);
			taken = o_op_ready;
			@(posedge i_clk);
			#1;
		end
		i_op_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	initial begin
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		void'($urandom(32'h642b_ea23));
		i_reset       = 1'b1;
		i_op_valid    = 1'b0;
		i_op_is_store = 1'b0;
		i_op_addr     = '0;
		i_op_wdata    = '0;
		i_op_rd       = '0;
		repeat (5) @(posedge i_clk);
		#1 i_reset = 1'b0;
		idle_cycles(2);

		for (int i = 0; i < N_INIT; i++)
			send_op(1'b1, ADDR_W'(i), $urandom, '0);

		// Bursts push each queue toward full
		for (int i = 0; i < N_BURST; i++)
			send_op(1'b1, ADDR_W'($urandom % 8), $urandom, '0);
		for (int i = 0; i < N_BURST; i++)
			send_op(1'b0, ADDR_W'($urandom % 8), '0, RD_W'(i));

		for (int i = 0; i < N_PAIRS; i++) begin
			a = ADDR_W'($urandom % 8);
			d = $urandom;
			send_op(1'b1, a, d, '0);
			send_op(1'b0, a, '0, RD_W'(i + 8));  // Must see d
		end

		for (int i = 0; i < N_RAND; i++) begin
			send_op(1'(($urandom % 2)), ADDR_W'($urandom % 8), $urandom, RD_W'($urandom % 32));
			if ($urandom % 4 == 0)
				idle_cycles(int'($urandom % 3) + 1);
		end

		for (int w = 0; w < DRAIN_LIMIT && exp_q.size() != 0; w++)
			@(posedge i_clk);
		idle_cycles(3);
		stim_done = 1'b1;
		idle_cycles(3);

		$display("Back-pressure cycles: store %0d, load %0d", st_stalls, ld_stalls);
		$display("Error counts: data %0d, order %0d, other %0d",
			data_errs, order_errs, other_errs);
		if (data_errs + order_errs + other_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles with %0d load responses outstanding",
				cycles, exp_q.size());
			$display("Error counts: data %0d, order %0d, other %0d",
				data_errs, order_errs, other_errs);
			$display("Errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* hdl/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
	input  wire                           i_clk,
	input  wire                           i_reset,
	input  wire                           i_op_valid,
	output logic                          o_op_ready,
	input  wire                           i_op_is_store,
	input  wire [lsq_cfg_pkg::ADDR_W-1:0] i_op_addr,
	input  wire [lsq_cfg_pkg::DATA_W-1:0] i_op_wdata,
	input  wire [lsq_cfg_pkg::RD_W-1:0]   i_op_rd,
	output logic                          o_ld_valid,
	output logic [lsq_cfg_pkg::RD_W-1:0]  o_ld_rd,
	output logic [lsq_cfg_pkg::DATA_W-1:0] o_ld_data
);
	import lsq_cfg_pkg::*;
	import lsq_types_pkg::*;

	op_t                        op;
	logic                       st_valid, st_ready;
	logic                       ld_valid, ld_ready;
	saq_entry_t [SAQ_DEPTH-1:0] saq_entries;
	laq_entry_t [LAQ_DEPTH-1:0] laq_entries;
	logic [ADDR_W-1:0]          st_head_addr, ld_head_addr;
	seq_t                       st_head_seq, ld_head_seq;
	logic                       st_blocked, ld_blocked;

	mem_req_if st_mem ();
	mem_req_if ld_mem ();
	mem_req_if sram_mem ();

	op_dispatch u_dispatch (
		.i_clk, .i_reset, .i_op_valid, .o_op_ready, .i_op_is_store, .i_op_addr,
		.i_op_wdata, .i_op_rd,
		.o_st_valid(st_valid), .i_st_ready(st_ready),
		.o_ld_valid(ld_valid), .i_ld_ready(ld_ready), .o_op(op)
	);

	addr_comparator u_comp (
		.i_saq(saq_entries), .i_laq(laq_entries),
		.i_ld_addr(ld_head_addr), .i_ld_seq(ld_head_seq),
		.i_st_addr(st_head_addr), .i_st_seq(st_head_seq),
		.o_ld_blocked(ld_blocked), .o_st_blocked(st_blocked)
	);

	// Queues --------------------
	store_queue u_saq (
		.i_clk, .i_reset, .i_valid(st_valid), .o_ready(st_ready), .i_op(op),
		.o_entries(saq_entries), .o_head_addr(st_head_addr), .o_head_seq(st_head_seq),
		.i_blocked(st_blocked), .mem(st_mem.requester)
	);

	load_queue u_laq (
		.i_clk, .i_reset, .i_valid(ld_valid), .o_ready(ld_ready), .i_op(op),
		.o_entries(laq_entries), .o_head_addr(ld_head_addr), .o_head_seq(ld_head_seq),
		.i_blocked(ld_blocked), .mem(ld_mem.requester),
		.o_ld_valid, .o_ld_rd, .o_ld_data
	);

	// Shared memory port --------------------
	mem_port_arbiter u_arb (
		.i_clk, .i_reset, .st(st_mem.responder), .ld(ld_mem.responder),
		.mem(sram_mem.requester)
	);

	data_sram u_sram (.i_clk, .mem(sram_mem.responder));

endmodule

`default_nettype wire

/* hdl/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram (
	input  wire          i_clk,
	mem_req_if.responder mem
);
	import lsq_cfg_pkg::*;

	logic [DATA_W-1:0] ram_q [2**ADDR_W];

	assign mem.ready = 1'b1;  // Single cycle access, never stalls

	always_ff @(posedge i_clk) begin
		if (mem.valid && mem.we)
			ram_q[mem.addr] <= mem.wdata;
		if (mem.valid && !mem.we)
			mem.rdata <= ram_q[mem.addr];
		mem.rvalid <= mem.valid & ~mem.we;
	end

endmodule

`default_nettype wire

/* hdl/mem_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
	input  wire          i_clk,
	input  wire          i_reset,
	mem_req_if.responder st,
	mem_req_if.responder ld,
	mem_req_if.requester mem
);
	logic last_ld_q;  // Load side won the last transfer
	logic grant_ld;
	logic grant_st;

	assign grant_ld = ld.valid & (~st.valid | ~last_ld_q);
	assign grant_st = st.valid & ~grant_ld;

	assign mem.valid = st.valid | ld.valid;
	assign mem.we    = grant_st ? st.we    : ld.we;
	assign mem.addr  = grant_st ? st.addr  : ld.addr;
	assign mem.wdata = grant_st ? st.wdata : ld.wdata;

	assign st.ready = grant_st & mem.ready;
	assign ld.ready = grant_ld & mem.ready;

	// Only loads read, so responses go to the load side
	assign ld.rvalid = mem.rvalid;
	assign ld.rdata  = mem.rdata;
	assign st.rvalid = 1'b0;
	assign st.rdata  = '0;

	always_ff @(posedge i_clk) begin
		if (i_reset)
			last_ld_q <= 1'b0;
		else if (mem.valid && mem.ready)
			last_ld_q <= grant_ld;
	end

endmodule

`default_nettype wire

/* hdl/load_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module load_queue (
	input  wire                                                    i_clk,
	input  wire                                                    i_reset,
	input  wire                                                    i_valid,
	output logic                                                   o_ready,
	input  lsq_types_pkg::op_t                                     i_op,
	output lsq_types_pkg::laq_entry_t [lsq_cfg_pkg::LAQ_DEPTH-1:0] o_entries,
	output logic [lsq_cfg_pkg::ADDR_W-1:0]                         o_head_addr,
	output lsq_types_pkg::seq_t                                    o_head_seq,
	input  wire                                                    i_blocked,
	mem_req_if.requester                                           mem,
	output logic                                                   o_ld_valid,
	output logic [lsq_cfg_pkg::RD_W-1:0]                           o_ld_rd,
	output logic [lsq_cfg_pkg::DATA_W-1:0]                         o_ld_data
);
	import lsq_cfg_pkg::*;
	import lsq_types_pkg::*;

	laq_entry_t [LAQ_DEPTH-1:0] ent_q;
	logic [LAQ_IDX_W-1:0]       alloc_q;
	logic [LAQ_IDX_W-1:0]       issue_q;
	logic [LAQ_IDX_W-1:0]       retire_q;
	logic [LAQ_IDX_W:0]         count_q;  // Allocated and not yet retired
	logic                       push;
	logic                       issue;
	logic                       retire;

	assign o_ready = (count_q != (LAQ_IDX_W + 1)'(LAQ_DEPTH));
	assign push    = i_valid & o_ready;
	assign issue   = mem.valid & mem.ready;
	assign retire  = mem.rvalid;

	assign o_entries   = ent_q;
	assign o_head_addr = ent_q[issue_q].addr;
	assign o_head_seq  = ent_q[issue_q].seq;

	// Issue the oldest unissued load --------------------
	assign mem.valid = ent_q[issue_q].live & ~ent_q[issue_q].issued & ~i_blocked;
	assign mem.we    = 1'b0;
	assign mem.addr  = ent_q[issue_q].addr;
	assign mem.wdata = '0;

	// Reads come back in issue order, so the retire entry owns the data
	assign o_ld_valid = mem.rvalid;
	assign o_ld_rd    = ent_q[retire_q].rd;
	assign o_ld_data  = mem.rdata;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			alloc_q  <= '0;
			issue_q  <= '0;
			retire_q <= '0;
			count_q  <= '0;
			for (int i = 0; i < LAQ_DEPTH; i++) begin
				ent_q[i].live   <= 1'b0;
				ent_q[i].issued <= 1'b0;
			end
		end else begin
			if (push) begin
				ent_q[alloc_q] <= '{live: 1'b1, issued: 1'b0, addr: i_op.addr,
					rd: i_op.rd, seq: i_op.seq};
				alloc_q <= alloc_q + 1'b1;
			end
			if (issue) begin
				ent_q[issue_q].issued <= 1'b1;
				issue_q               <= issue_q + 1'b1;
			end
			if (retire) begin
				ent_q[retire_q].live <= 1'b0;
				retire_q             <= retire_q + 1'b1;
			end
			count_q <= count_q + {{LAQ_IDX_W{1'b0}}, push} - {{LAQ_IDX_W{1'b0}}, retire};
		end
	end

endmodule

`default_nettype wire

/* hdl/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
	input  wire                                                    i_clk,
	input  wire                                                    i_reset,
	input  wire                                                    i_valid,
	output logic                                                   o_ready,
	input  lsq_types_pkg::op_t                                     i_op,
	output lsq_types_pkg::saq_entry_t [lsq_cfg_pkg::SAQ_DEPTH-1:0] o_entries,
	output logic [lsq_cfg_pkg::ADDR_W-1:0]                         o_head_addr,
	output lsq_types_pkg::seq_t                                    o_head_seq,
	input  wire                                                    i_blocked,
	mem_req_if.requester                                           mem
);
	import lsq_cfg_pkg::*;
	import lsq_types_pkg::*;

	saq_entry_t [SAQ_DEPTH-1:0] ent_q;
	logic [SAQ_IDX_W-1:0]       head_q;
	logic [SAQ_IDX_W-1:0]       tail_q;
	logic [SAQ_IDX_W:0]         count_q;
	logic                       push;
	logic                       pop;

	assign o_ready = (count_q != (SAQ_IDX_W + 1)'(SAQ_DEPTH));
	assign push    = i_valid & o_ready;
	assign pop     = mem.valid & mem.ready;  // Write granted

	assign o_entries   = ent_q;
	assign o_head_addr = ent_q[head_q].addr;
	assign o_head_seq  = ent_q[head_q].seq;

	// Memory write request --------------------
	assign mem.valid = (count_q != '0) & ~i_blocked;
	assign mem.we    = 1'b1;
	assign mem.addr  = ent_q[head_q].addr;
	assign mem.wdata = ent_q[head_q].data;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			for (int i = 0; i < SAQ_DEPTH; i++)
				ent_q[i].live <= 1'b0;
		end else begin
			if (push) begin
				ent_q[tail_q] <= '{live: 1'b1, addr: i_op.addr, data: i_op.data, seq: i_op.seq};
				tail_q        <= tail_q + 1'b1;
			end
			if (pop) begin
				ent_q[head_q].live <= 1'b0;
				head_q             <= head_q + 1'b1;
			end
			count_q <= count_q + {{SAQ_IDX_W{1'b0}}, push} - {{SAQ_IDX_W{1'b0}}, pop};
		end
	end

endmodule

`default_nettype wire

/* hdl/addr_comparator.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_comparator (
	input  lsq_types_pkg::saq_entry_t [lsq_cfg_pkg::SAQ_DEPTH-1:0] i_saq,
	input  lsq_types_pkg::laq_entry_t [lsq_cfg_pkg::LAQ_DEPTH-1:0] i_laq,
	input  wire [lsq_cfg_pkg::ADDR_W-1:0]                          i_ld_addr,
	input  lsq_types_pkg::seq_t                                    i_ld_seq,
	input  wire [lsq_cfg_pkg::ADDR_W-1:0]                          i_st_addr,
	input  lsq_types_pkg::seq_t                                    i_st_seq,
	output logic                                                   o_ld_blocked,
	output logic                                                   o_st_blocked
);
	import lsq_cfg_pkg::*;
	import lsq_types_pkg::*;

	logic [SAQ_DEPTH-1:0] saq_hit;
	logic [LAQ_DEPTH-1:0] laq_hit;

	// SAQ against load head --------------------
	for (genvar i = 0; i < SAQ_DEPTH; i++) begin : g_saq
		saq_entry_t ent;
		seq_t       age;

		assign ent = i_saq[i];
		assign age = ent.seq - i_ld_seq;  // Top bit set when entry is older
		assign saq_hit[i] = ent.live & (ent.addr == i_ld_addr) & age[SEQ_W-1];
	end

	// LAQ against store head --------------------
	for (genvar i = 0; i < LAQ_DEPTH; i++) begin : g_laq
		laq_entry_t ent;
		seq_t       age;

		assign ent = i_laq[i];
		assign age = ent.seq - i_st_seq;
		// Issued loads already read memory, so they cannot be hurt by the store
		assign laq_hit[i] = ent.live & ~ent.issued & (ent.addr == i_st_addr)
			& age[SEQ_W-1];
	end

	assign o_ld_blocked = |saq_hit;
	assign o_st_blocked = |laq_hit;

endmodule

`default_nettype wire

/* hdl/op_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module op_dispatch (
	input  wire                             i_clk,
	input  wire                             i_reset,
	input  wire                             i_op_valid,
	output logic                            o_op_ready,
	input  wire                             i_op_is_store,
	input  wire [lsq_cfg_pkg::ADDR_W-1:0]   i_op_addr,
	input  wire [lsq_cfg_pkg::DATA_W-1:0]   i_op_wdata,
	input  wire [lsq_cfg_pkg::RD_W-1:0]     i_op_rd,
	output logic                            o_st_valid,
	input  wire                             i_st_ready,
	output logic                            o_ld_valid,
	input  wire                             i_ld_ready,
	output lsq_types_pkg::op_t              o_op
);
	import lsq_types_pkg::*;

	seq_t seq_q;  // Age tag for the next operation

	assign o_st_valid = i_op_valid & i_op_is_store;
	assign o_ld_valid = i_op_valid & ~i_op_is_store;
	assign o_op_ready = i_op_is_store ? i_st_ready : i_ld_ready;

	assign o_op = '{is_store: i_op_is_store, addr: i_op_addr, data: i_op_wdata,
		rd: i_op_rd, seq: seq_q};

	always_ff @(posedge i_clk) begin
		if (i_reset)
			seq_q <= '0;
		else if (i_op_valid && o_op_ready)
			seq_q <= seq_q + 1'b1;
	end

endmodule

`default_nettype wire

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
	import lsq_cfg_pkg::*;

	logic              valid;
	logic              ready;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              rvalid;  // One cycle after a read transfer
	logic [DATA_W-1:0] rdata;

	modport requester (
		output valid, we, addr, wdata,
		input  ready, rvalid, rdata
	);

	modport responder (
		input  valid, we, addr, wdata,
		output ready, rvalid, rdata
	);

endinterface

`default_nettype wire

/* hdl/lsq_types_pkg.sv */
`default_nettype none

package lsq_types_pkg;

	typedef logic [lsq_cfg_pkg::SEQ_W-1:0] seq_t;

	typedef struct packed {
		logic                              live;
		logic [lsq_cfg_pkg::ADDR_W-1:0]    addr;
		logic [lsq_cfg_pkg::DATA_W-1:0]    data;
		seq_t                              seq;
	} saq_entry_t;

	typedef struct packed {
		logic                              live;
		logic                              issued;  // Sent to memory, waiting for data
		logic [lsq_cfg_pkg::ADDR_W-1:0]    addr;
		logic [lsq_cfg_pkg::RD_W-1:0]      rd;
		seq_t                              seq;
	} laq_entry_t;

	typedef struct packed {
		logic                              is_store;
		logic [lsq_cfg_pkg::ADDR_W-1:0]    addr;
		logic [lsq_cfg_pkg::DATA_W-1:0]    data;
		logic [lsq_cfg_pkg::RD_W-1:0]      rd;
		seq_t                              seq;
	} op_t;

endpackage

`default_nettype wire

/* hdl/lsq_cfg_pkg.sv */
`default_nettype none

package lsq_cfg_pkg;

	// Queue sizes --------------------
	localparam int SAQ_DEPTH = 4;
	localparam int LAQ_DEPTH = 4;
	localparam int SAQ_IDX_W = 2;
	localparam int LAQ_IDX_W = 2;

	// Datapath widths --------------------
	localparam int ADDR_W = 6;  // Word address
	localparam int DATA_W = 32;
	localparam int RD_W   = 5;

	// One spare bit over the in-flight count keeps age compares valid across wrap
	localparam int SEQ_W = 4;

endpackage

`default_nettype wire
